// ==== design/histPkg.sv ====
`default_nettype none

package histPkg;

    // raw tdc stamp width
    localparam int stampBits = 10;

    // histogram geometry
    localparam int binAddrBits = 6;
    localparam int binNum = 64;
    // low stamp bits dropped per bin, 4 codes per bin
    localparam int binShift = 2;

    // bin counts saturate at all ones
    localparam int countBits = 4;
    localparam logic [countBits-1:0] countMax = '1;

    // accepted events per frame
    localparam int frameEvents = 40;
    localparam int frameCountBits = $clog2(frameEvents);
    localparam logic [frameCountBits-1:0] frameLast = frameCountBits'(frameEvents - 1);

    // offset-relative stamp after the shift, still wider than a bin address
    localparam int relBinBits = stampBits - binShift;
    localparam logic [relBinBits-1:0] binLimit = relBinBits'(binNum);
    // last bin address, end of clear and scan
    localparam logic [binAddrBits-1:0] binLast = binAddrBits'(binNum - 1);

    // quantizer to builder
    typedef struct packed {
        logic                   valid;
        logic [binAddrBits-1:0] bin;
    } binEvent_t;

    // builder write port into the bin memory
    typedef struct packed {
        logic                   en;
        logic [binAddrBits-1:0] addr;
        logic [countBits-1:0]   data;
    } ramWrite_t;

    // one read requester, builder or peak finder
    typedef struct packed {
        logic                   en;
        logic [binAddrBits-1:0] addr;
    } ramRead_t;

    // peak finder result
    typedef struct packed {
        logic [binAddrBits-1:0] bin;
        logic [countBits-1:0]   count;
    } peakResult_t;

endpackage

`default_nettype wire

// ==== design/tdcBinQuantizer.sv ====
`timescale 1ns/1ps
`default_nettype none

module tdcBinQuantizer (
    input  logic                         clk,
    input  logic                         res,
    input  logic [histPkg::stampBits-1:0] stamp,
    input  logic                         stampStrobe,
    input  logic [histPkg::stampBits-1:0] windowOffset,
    output histPkg::binEvent_t           binEvent
);

    // stamp relative to the window start
    logic [histPkg::stampBits-1:0] relStamp;
    // relative stamp with the sub-bin bits removed
    logic [histPkg::relBinBits-1:0] relBin;
    logic belowWindow;
    logic beyondWindow;
    logic inWindow;

    // stamp earlier than the window, the subtraction below would wrap
    assign belowWindow = stamp < windowOffset;

    assign relStamp = stamp - windowOffset;

    // drop the low bits, 4 stamp codes share one bin
    assign relBin = relStamp[histPkg::stampBits-1:histPkg::binShift];

    // past the last bin
    assign beyondWindow = relBin >= histPkg::binLimit;

    // only range check in the design
    assign inWindow = !belowWindow && !beyondWindow;

    // one cycle from strobe to event
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            binEvent <= '0;
        end else begin
            // out of window stamps never leave as valid
            binEvent.valid <= stampStrobe && inWindow;
            // upper relBin bits are zero whenever valid is set
            binEvent.bin <= relBin[histPkg::binAddrBits-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== design/histBuilder.sv ====
`timescale 1ns/1ps
`default_nettype none

module histBuilder (
    input  logic                          clk,
    input  logic                          res,
    input  logic                          start,
    input  histPkg::binEvent_t            binEvent,
    input  logic [histPkg::countBits-1:0] rdData,
    output histPkg::ramRead_t             rdReq,
    output histPkg::ramWrite_t            wrReq,
    output logic                          accumulating,
    output logic                          buildDone
);

    typedef enum logic [1:0] {
        IDLE,
        CLEAR,
        ACCUM,
        FLUSH
    } state_t;

    state_t state;
    state_t nextState;

    // clear pointer, walks all bins once
    logic [histPkg::binAddrBits-1:0] clrAddr;
    // accepted events in this frame
    logic [histPkg::frameCountBits-1:0] evtCount;
    // second flush cycle
    logic flushCnt;

    logic accept;
    logic lastEvent;

    // stage 1, event whose read data is on rdData now
    logic                            s1Valid;
    logic [histPkg::binAddrBits-1:0] s1Bin;

    // copy of the previous write, for the read-during-write hazard
    logic                            fwdValid;
    logic [histPkg::binAddrBits-1:0] fwdAddr;
    logic [histPkg::countBits-1:0]   fwdData;

    logic [histPkg::countBits-1:0] curCount;
    logic [histPkg::countBits-1:0] incCount;

    // events outside accumulate are dropped here
    assign accept = (state == ACCUM) && binEvent.valid;
    assign lastEvent = accept && (evtCount == histPkg::frameLast);

    assign accumulating = (state == ACCUM);

    always_comb begin
        nextState = state;
        case (state)
            IDLE: begin
                if (start) begin
                    nextState = CLEAR;
                end
            end
            CLEAR: begin
                if (clrAddr == histPkg::binLast) begin
                    nextState = ACCUM;
                end
            end
            ACCUM: begin
                // frame full, stop taking events
                if (lastEvent) begin
                    nextState = FLUSH;
                end
            end
            FLUSH: begin
                if (flushCnt) begin
                    nextState = IDLE;
                end
            end
            default: begin
                nextState = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= IDLE;
            clrAddr <= '0;
            evtCount <= '0;
            flushCnt <= 1'b0;
            buildDone <= 1'b0;
        end else begin
            state <= nextState;
            // pointer rests at zero outside clear
            clrAddr <= (state == CLEAR) ? clrAddr + 1'b1 : '0;
            if (state != ACCUM) begin
                evtCount <= '0;
            end else if (accept) begin
                evtCount <= evtCount + 1'b1;
            end
            flushCnt <= (state == FLUSH) ? ~flushCnt : 1'b0;
            // one cycle pulse as the FSM returns to idle
            buildDone <= (state == FLUSH) && flushCnt;
        end
    end

    // stage 0, read request straight from the event
    always_comb begin
        rdReq.en = accept;
        rdReq.addr = binEvent.bin;
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1Valid <= 1'b0;
            fwdValid <= 1'b0;
        end else begin
            s1Valid <= accept;
            fwdValid <= wrReq.en;
        end
    end

    always_ff @(posedge clk) begin
        s1Bin <= binEvent.bin;
        fwdAddr <= wrReq.addr;
        fwdData <= wrReq.data;
    end

    // same bin written last cycle, memory returned the stale count
    assign curCount = (fwdValid && (fwdAddr == s1Bin)) ? fwdData : rdData;

    // saturating increment
    assign incCount = (curCount == histPkg::countMax) ? curCount : curCount + 1'b1;

    // stage 1, write back; clear owns the port while it runs
    always_comb begin
        if (state == CLEAR) begin
            wrReq.en = 1'b1;
            wrReq.addr = clrAddr;
            wrReq.data = '0;
        end else begin
            wrReq.en = s1Valid;
            wrReq.addr = s1Bin;
            wrReq.data = incCount;
        end
    end

endmodule

`default_nettype wire

// ==== design/histRam.sv ====
`timescale 1ns/1ps
`default_nettype none

module histRam (
    input  logic                          clk,
    input  histPkg::ramWrite_t            wrReq,
    input  histPkg::ramRead_t             builderRd,
    input  histPkg::ramRead_t             peakRd,
    output logic [histPkg::countBits-1:0] rdData
);

    // one count word per bin
    logic [histPkg::countBits-1:0] mem [histPkg::binNum];

    // selected read request
    histPkg::ramRead_t rdSel;

    // builder and peak finder never read in the same phase
    // builder first when both would ask
    always_comb begin
        if (builderRd.en) begin
            rdSel = builderRd;
        end else begin
            rdSel = peakRd;
        end
    end

    // write port
    always_ff @(posedge clk) begin
        if (wrReq.en) begin
            mem[wrReq.addr] <= wrReq.data;
        end
    end

    // read port, one cycle latency
    // same address as a write in this cycle gives the old word
    always_ff @(posedge clk) begin
        if (rdSel.en) begin
            rdData <= mem[rdSel.addr];
        end
    end

endmodule

`default_nettype wire

// ==== design/peakFinder.sv ====
`timescale 1ns/1ps
`default_nettype none

module peakFinder (
    input  logic                          clk,
    input  logic                          res,
    input  logic                          scanStart,
    input  logic [histPkg::countBits-1:0] rdData,
    output histPkg::ramRead_t             rdReq,
    output histPkg::peakResult_t          peak,
    output logic                          peakValid
);

    typedef enum logic {
        IDLE,
        SCAN
    } state_t;

    state_t state;

    // next bin to read
    logic [histPkg::binAddrBits-1:0] scanAddr;

    // compare stage, bin whose count is on rdData
    logic                            cmpValid;
    logic [histPkg::binAddrBits-1:0] cmpAddr;
    logic                            cmpLast;

    // running maximum
    logic [histPkg::binAddrBits-1:0] maxBin;
    logic [histPkg::countBits-1:0]   maxCount;

    logic takeNew;

    // one read per cycle while scanning
    always_comb begin
        rdReq.en = (state == SCAN);
        rdReq.addr = scanAddr;
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= IDLE;
            scanAddr <= '0;
            cmpValid <= 1'b0;
        end else begin
            cmpValid <= rdReq.en;
            case (state)
                IDLE: begin
                    scanAddr <= '0;
                    // a start during a scan is ignored
                    if (scanStart) begin
                        state <= SCAN;
                    end
                end
                SCAN: begin
                    scanAddr <= scanAddr + 1'b1;
                    if (scanAddr == histPkg::binLast) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        cmpAddr <= scanAddr;
    end

    assign cmpLast = (cmpAddr == histPkg::binLast);

    // bin 0 seeds the maximum
    // strictly greater, so the lower bin keeps a tie
    assign takeNew = (cmpAddr == '0) || (rdData > maxCount);

    always_ff @(posedge clk) begin
        if (cmpValid && takeNew) begin
            maxBin <= cmpAddr;
            maxCount <= rdData;
        end
    end

    // result registered with the last compare, held until the next scan ends
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            peak <= '0;
            peakValid <= 1'b0;
        end else begin
            peakValid <= cmpValid && cmpLast;
            if (cmpValid && cmpLast) begin
                if (takeNew) begin
                    peak <= '{bin: cmpAddr, count: rdData};
                end else begin
                    peak <= '{bin: maxBin, count: maxCount};
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/histTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module histTop (
    input  logic                          clk,
    input  logic                          res,
    input  logic                          start,
    input  logic [histPkg::stampBits-1:0] windowOffset,
    input  logic [histPkg::stampBits-1:0] stamp,
    input  logic                          stampStrobe,
    output logic                          accumulating,
    output logic                          buildDone,
    output histPkg::peakResult_t          peak,
    output logic                          peakValid
);

    // quantizer to builder
    histPkg::binEvent_t binEvent;

    // memory ports
    histPkg::ramWrite_t wrReq;
    histPkg::ramRead_t  builderRd;
    histPkg::ramRead_t  peakRd;
    // shared read data, goes to both requesters
    logic [histPkg::countBits-1:0] rdData;

    // stamp to bin address
    tdcBinQuantizer quantizer (
        .clk          (clk),
        .res          (res),
        .stamp        (stamp),
        .stampStrobe  (stampStrobe),
        .windowOffset (windowOffset),
        .binEvent     (binEvent)
    );

    // clear, then count events into the memory
    histBuilder builder (
        .clk          (clk),
        .res          (res),
        .start        (start),
        .binEvent     (binEvent),
        .rdData       (rdData),
        .rdReq        (builderRd),
        .wrReq        (wrReq),
        .accumulating (accumulating),
        .buildDone    (buildDone)
    );

    histRam ram (
        .clk       (clk),
        .wrReq     (wrReq),
        .builderRd (builderRd),
        .peakRd    (peakRd),
        .rdData    (rdData)
    );

    // scan starts on the builder's done pulse
    peakFinder finder (
        .clk       (clk),
        .res       (res),
        .scanStart (buildDone),
        .rdData    (rdData),
        .rdReq     (peakRd),
        .peak      (peak),
        .peakValid (peakValid)
    );

endmodule

`default_nettype wire

// ==== sim/histTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module histTb;

    localparam int countSat = (1 << histPkg::countBits) - 1;
    localparam int stampMax = (1 << histPkg::stampBits) - 1;
    // window width in stamp codes
    localparam int windowSpan = histPkg::binNum << histPkg::binShift;
    localparam int clearTimeout = 200;
    localparam int doneTimeout = 20;
    localparam int peakTimeout = 200;
    // pipeline drain between frame close and the done pulse
    localparam int flushCycles = 2;
    // done pulse to peakValid, one read per bin plus read and result stages
    localparam int scanCycles = histPkg::binNum + 2;

    // one table row, a full frame
    typedef struct packed {
        int offset;
        int hot;
        int repeats;
        int outCount;
        bit filler;
    } testRow_t;

    logic                          clk;
    logic                          res;
    logic                          start;
    logic [histPkg::stampBits-1:0] windowOffset;
    logic [histPkg::stampBits-1:0] stamp;
    logic                          stampStrobe;
    logic                          accumulating;
    logic                          buildDone;
    histPkg::peakResult_t          peak;
    logic                          peakValid;

    testRow_t rowTable [$];
    string rowName [$];
    int stampQ [$];
    int modelHist [$];
    int passCount;
    int failCount;

    histTop DUT (
        .clk          (clk),
        .res          (res),
        .start        (start),
        .windowOffset (windowOffset),
        .stamp        (stamp),
        .stampStrobe  (stampStrobe),
        .accumulating (accumulating),
        .buildDone    (buildDone),
        .peak         (peak),
        .peakValid    (peakValid)
    );

    // 40 ns period
    always #20 clk = ~clk;

    // range rule, stamp below the offset or past the last bin is lost
    function automatic bit inWindow(input int s, input int off);
        return (s >= off) && (((s - off) >> histPkg::binShift) < histPkg::binNum);
    endfunction

    // even k below the window when possible, else past its end
    function automatic int outStamp(input int off, input int k);
        int lo;
        lo = off + windowSpan;
        if (((k % 2 == 0) && (off > 0)) || (lo > stampMax)) begin
            return $urandom % off;
        end
        return lo + ($urandom % (stampMax + 1 - lo));
    endfunction

    task automatic addRow(input string name, input int off, input int hot, input int rep,
                          input int outN, input bit fill);
        testRow_t r;
        r = '{offset: off, hot: hot, repeats: rep, outCount: outN, filler: fill};
        rowTable.push_back(r);
        rowName.push_back(name);
    endtask

    // stamp order: half the strays, hot run, other strays, then filler
    task automatic buildStamps(input testRow_t row);
        int k;
        stampQ.delete();
        for (k = 0; k < row.outCount / 2; k++) begin
            stampQ.push_back(outStamp(row.offset, k));
        end
        for (k = 0; k < row.repeats; k++) begin
            stampQ.push_back(row.hot);
        end
        for (k = row.outCount / 2; k < row.outCount; k++) begin
            stampQ.push_back(outStamp(row.offset, k));
        end
        for (k = row.repeats; k < histPkg::frameEvents; k++) begin
            if (row.filler) begin
                stampQ.push_back(row.offset + int'($urandom % windowSpan));
            end else begin
                // round robin over the first three bins
                stampQ.push_back(row.offset + ((k % 3) << histPkg::binShift));
            end
        end
        // spares, arrive after the frame has closed
        repeat (3) stampQ.push_back(row.hot);
    endtask

    // reference histogram, returns the 1-based position of the closing stamp
    function automatic int modelFrame(input int off, output int expBin, output int expCount);
        int accepted;
        int pos;
        int s;
        int b;
        modelHist.delete();
        repeat (histPkg::binNum) modelHist.push_back(0);
        accepted = 0;
        pos = 0;
        while ((accepted < histPkg::frameEvents) && (pos < stampQ.size())) begin
            s = stampQ[pos];
            pos++;
            if (inWindow(s, off)) begin
                b = (s - off) >> histPkg::binShift;
                if (modelHist[b] < countSat) begin
                    modelHist[b]++;
                end
                accepted++;
            end
        end
        // strict compare keeps the lowest bin on a tie
        expBin = 0;
        expCount = modelHist[0];
        for (b = 1; b < histPkg::binNum; b++) begin
            if (modelHist[b] > expCount) begin
                expBin = b;
                expCount = modelHist[b];
            end
        end
        return pos;
    endfunction

    task automatic runRow(input int idx);
        testRow_t row;
        int closePos;
        int expBin;
        int expCount;
        int driven;
        int timer;
        bit ok;
        row = rowTable[idx];
        ok = 1'b1;
        buildStamps(row);
        closePos = modelFrame(row.offset, expBin, expCount);

        windowOffset = histPkg::stampBits'(row.offset);
        start = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;

        // clear phase runs before accumulating rises
        timer = 0;
        while (!accumulating && (timer < clearTimeout)) begin
            @(posedge clk);
            #2;
            timer++;
        end
        assert (accumulating) else begin
            $display("row %0d: accumulating never rose after start", idx);
            ok = 1'b0;
        end

        // one stamp per cycle until the frame closes
        driven = 0;
        while (ok && accumulating && (driven < stampQ.size())) begin
            stamp = histPkg::stampBits'(stampQ[driven]);
            stampStrobe = 1'b1;
            driven++;
            @(posedge clk);
            #2;
        end
        stampStrobe = 1'b0;

        if (ok) begin
            assert (!accumulating) else begin
                $display("row %0d: frame still open after all %0d stamps", idx, driven);
                ok = 1'b0;
            end
        end
        if (ok) begin
            // closing stamp plus one more still in the quantizer
            assert (driven == closePos + 1) else begin
                $display("Error at %0t ns: row %0d frame closed after %0d stamps, expected %0d",
                         $time, idx, driven, closePos + 1);
                ok = 1'b0;
            end
            // pipeline drains, then the done pulse
            timer = 0;
            while (!buildDone && (timer < doneTimeout)) begin
                @(posedge clk);
                #2;
                timer++;
            end
            assert (buildDone) else begin
                $display("row %0d: no buildDone pulse after the frame", idx);
                ok = 1'b0;
            end
            if (buildDone) begin
                assert (timer == flushCycles) else begin
                    $display("Error at %0t ns: row %0d buildDone %0d cycles after close, expected %0d",
                             $time, idx, timer, flushCycles);
                    ok = 1'b0;
                end
                @(posedge clk);
                #2;
                assert (!buildDone) else begin
                    $display("Error at %0t ns: row %0d buildDone longer than one cycle",
                             $time, idx);
                    ok = 1'b0;
                end
                // scan counted from the done pulse
                timer = 1;
                while (!peakValid && (timer < peakTimeout)) begin
                    @(posedge clk);
                    #2;
                    timer++;
                end
                assert (peakValid) else begin
                    $display("row %0d: no peakValid pulse after the frame", idx);
                    ok = 1'b0;
                end
                if (peakValid) begin
                    assert (timer == scanCycles) else begin
                        $display("Error at %0t ns: row %0d peakValid %0d cycles after done, expected %0d",
                                 $time, idx, timer, scanCycles);
                        ok = 1'b0;
                    end
                    assert (int'(peak.bin) == expBin) else begin
                        $display("Error at %0t ns: row %0d peak bin expected %0d, got %0d",
                                 $time, idx, expBin, peak.bin);
                        ok = 1'b0;
                    end
                    assert (int'(peak.count) == expCount) else begin
                        $display("Error at %0t ns: row %0d peak count expected %0d, got %0d",
                                 $time, idx, expCount, peak.count);
                        ok = 1'b0;
                    end
                end
            end
        end

        if (ok) begin
            passCount++;
            $display("row %0d %s: pass, bin %0d count %0d", idx, rowName[idx], expBin, expCount);
        end else begin
            failCount++;
            $display("row %0d %s: fail", idx, rowName[idx]);
        end
    endtask

    initial begin
        int i;
        void'($urandom(55));
        clk = 1'b0;
        res = 1'b0;
        start = 1'b0;
        windowOffset = '0;
        stamp = '0;
        stampStrobe = 1'b0;
        passCount = 0;
        failCount = 0;

        // name, offset, hot stamp, repeats, strays, random filler
        addRow("basic peak", 100, 249, 12, 0, 1'b1);
        addRow("back-to-back repeats", 0, 40, 14, 0, 1'b1);
        addRow("saturation", 512, 700, 24, 0, 1'b1);
        addRow("out of window", 300, 400, 9, 20, 1'b1);
        // same window as before, old bin 25 must be gone
        addRow("clearing", 300, 500, 6, 4, 1'b1);
        // bins 0, 1, 2 and 50 all end at 10
        addRow("tie", 200, 400, 10, 0, 1'b0);

        repeat (10) @(posedge clk);
        #2;
        res = 1'b1;

        for (i = 0; i < rowTable.size(); i++) begin
            runRow(i);
        end

        $display("passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
design/histPkg.sv
design/tdcBinQuantizer.sv
design/histBuilder.sv
design/histRam.sv
design/peakFinder.sv
design/histTop.sv
sim/histTb.sv

// ==== run.sh ====
#!/bin/sh
# build the histogram testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --assert --timescale 1ns/1ps -f tb.f --top-module histTb \
    -Mdir "$BUILD_DIR" -o histTb > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/histTb" > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the run passes only on the exact pass line
if grep -qx "TEST OK" "$SIM_LOG"; then
    exit 0
fi

echo "pass line not found in $SIM_LOG"
exit 1
